//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 4;
    localparam int imm_w      = 10;
    localparam int opcode_w   = 7;
    localparam int num_regs   = 1 << reg_addr_w;
    localparam int flag_w     = 4;

    // instruction word layout
    localparam int op_msb  = 31;
    localparam int op_lsb  = 25;
    localparam int rd_msb  = 24;
    localparam int rd_lsb  = 21;
    localparam int rn_msb  = 20;
    localparam int rn_lsb  = 17;
    localparam int rm_msb  = 16;
    localparam int rm_lsb  = 13;
    localparam int p_bit   = 12;
    localparam int u_bit   = 11;
    localparam int w_bit   = 10;
    localparam int imm_msb = 9;
    localparam int imm_lsb = 0;

    // opcode class bits
    localparam int op_a_rn_bit  = 3;
    localparam int op_b_rm_bit  = 4;
    localparam int op_store_bit = 5;
    localparam int op_mem_bit   = 6;

    // NZCV positions in status
    localparam int flag_n = 3;
    localparam int flag_z = 2;
    localparam int flag_c = 1;
    localparam int flag_v = 0;

    localparam logic [data_w-1:0] reset_pc = '0;
    localparam logic [data_w-1:0] pc_step  = 32'd4;

    // bit 3: A from rn, bit 4: B from rm, bit 5: store, bit 6: memory class
    typedef enum logic [opcode_w-1:0] {
        NOP   = 7'b000_0000,
        HLT   = 7'b000_0001,
        MOV_I = 7'b000_0010,
        ADD_I = 7'b000_1000,
        SUB_I = 7'b000_1001,
        ADD_R = 7'b001_1000,
        SUB_R = 7'b001_1001,
        AND_R = 7'b001_1010,
        ORR_R = 7'b001_1011,
        XOR_R = 7'b001_1100,
        CMP_R = 7'b001_1101,
        LDR_I = 7'b100_1000,
        LDR_R = 7'b101_1000,
        STR_I = 7'b110_1000,
        STR_R = 7'b111_1000
    } op_e;

    typedef enum logic [3:0] {
        reset,
        load_pc_start,
        load_pc_loop,
        fetch,
        fetch_wait,
        decode,
        execute,
        memory,
        memory_wait,
        write_back,
        halt
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        ORR = 3'd3,
        XOR = 3'd4
    } alu_op_e;

endpackage

//--- src/cpu_controller.sv
`timescale 1ns/10ps

module cpu_controller
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  op_e     opcode,
    input  logic    P,
    input  logic    U,
    input  logic    W,
    input  logic    wb_ack,
    output logic    load_pc,
    output logic    sel_pc,
    output logic    load_ir,
    output logic    w_en1,
    output logic    w_en2,
    output logic    w_en3,
    output logic    en_A,
    output logic    en_B,
    output logic    sel_A,
    output logic    sel_B,
    output logic    sel_post_indexing,
    output alu_op_e alu_op,
    output logic    en_C,
    output logic    en_status,
    output logic    bus_req,
    output logic    bus_we,
    output logic    sel_addr_data,
    output logic    halted
);

    ctrl_state_e state;
    logic        is_mem;
    logic        is_store;
    logic        writes_rd;

    assign is_mem   = opcode[op_mem_bit];
    assign is_store = opcode[op_store_bit];

    // CMP only sets flags, NOP touches nothing
    assign writes_rd = !is_mem && (opcode != CMP_R) && (opcode != NOP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= reset;
        end else begin
            case (state)
                reset:         state <= load_pc_start;
                load_pc_start: state <= fetch;
                load_pc_loop:  state <= fetch;
                fetch: begin
                    // hold the bus until the word comes back
                    if (wb_ack) begin
                        state <= fetch_wait;
                    end
                end
                fetch_wait:    state <= decode;
                decode: begin
                    if (opcode == HLT) begin
                        state <= halt;
                    end else begin
                        state <= execute;
                    end
                end
                execute:       state <= memory;
                memory: begin
                    if (!is_mem || wb_ack) begin
                        state <= memory_wait;
                    end
                end
                memory_wait:   state <= write_back;
                write_back:    state <= load_pc_loop;
                halt:          state <= halt;
                default:       state <= reset;
            endcase
        end
    end

    always_comb begin
        load_pc           = 1'b0;
        sel_pc            = 1'b0;
        load_ir           = 1'b0;
        w_en1             = 1'b0;
        w_en2             = 1'b0;
        w_en3             = 1'b0;
        en_A              = 1'b0;
        en_B              = 1'b0;
        sel_A             = 1'b0;
        sel_B             = 1'b0;
        sel_post_indexing = 1'b0;
        alu_op            = ADD;
        en_C              = 1'b0;
        en_status         = 1'b0;
        bus_req           = 1'b0;
        bus_we            = 1'b0;
        sel_addr_data     = 1'b0;
        halted            = 1'b0;

        case (state)
            load_pc_start: begin
                load_pc = 1'b1;
                sel_pc  = 1'b1;
            end
            load_pc_loop: begin
                load_pc = 1'b1;
            end
            fetch: begin
                bus_req = 1'b1;
            end
            fetch_wait: begin
                // IR is valid by the time decode looks at it
                load_ir = 1'b1;
            end
            execute: begin
                en_A  = 1'b1;
                en_B  = 1'b1;
                // zero for A, immediate for B, unless the class bit says register
                sel_A = !opcode[op_a_rn_bit];
                sel_B = !opcode[op_b_rm_bit];
            end
            memory: begin
                en_C = 1'b1;
                if (is_mem) begin
                    alu_op            = U ? ADD : SUB;
                    sel_post_indexing = !P;
                    bus_req           = 1'b1;
                    bus_we            = is_store;
                    sel_addr_data     = 1'b1;
                    // base update lands on the ack cycle
                    w_en2             = wb_ack && (!P || W);
                end else begin
                    case (opcode)
                        SUB_R, SUB_I, CMP_R: alu_op = SUB;
                        AND_R:               alu_op = AND;
                        ORR_R:               alu_op = ORR;
                        XOR_R:               alu_op = XOR;
                        default:             alu_op = ADD;
                    endcase
                    w_en1     = writes_rd;
                    en_status = (opcode == CMP_R);
                end
            end
            write_back: begin
                // loads only
                w_en3 = is_mem && !is_store;
            end
            halt: begin
                halted = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/instr_fetch.sv
`timescale 1ns/10ps

module instr_fetch
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_pc,
    input  logic                  sel_pc,
    input  logic                  load_ir,
    input  logic [data_w-1:0]     wb_dat_i,
    input  logic                  wb_ack,
    output logic [data_w-1:0]     pc,
    output op_e                   opcode,
    output logic [reg_addr_w-1:0] rd,
    output logic [reg_addr_w-1:0] rn,
    output logic [reg_addr_w-1:0] rm,
    output logic                  P,
    output logic                  U,
    output logic                  W,
    output logic [imm_w-1:0]      imm
);

    logic [data_w-1:0] fetch_buf;
    logic [data_w-1:0] ir;

    // any ack refreshes the buffer, only the fetch one reaches the IR
    always_ff @(posedge clk) begin
        if (wb_ack) begin
            fetch_buf <= wb_dat_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
            ir <= '0;
        end else begin
            if (load_pc) begin
                pc <= sel_pc ? reset_pc : pc + pc_step;
            end
            if (load_ir) begin
                ir <= fetch_buf;
            end
        end
    end

    // field split
    assign opcode = op_e'(ir[op_msb:op_lsb]);
    assign rd     = ir[rd_msb:rd_lsb];
    assign rn     = ir[rn_msb:rn_lsb];
    assign rm     = ir[rm_msb:rm_lsb];
    assign P      = ir[p_bit];
    assign U      = ir[u_bit];
    assign W      = ir[w_bit];
    assign imm    = ir[imm_msb:imm_lsb];

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps

module register_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [reg_addr_w-1:0] rn,
    input  logic [reg_addr_w-1:0] rm,
    input  logic                  w_en1,
    input  logic                  w_en2,
    input  logic                  w_en3,
    input  logic [data_w-1:0]     alu_result,
    input  logic [data_w-1:0]     base_result,
    input  logic [data_w-1:0]     load_data,
    output logic [data_w-1:0]     rn_data,
    output logic [data_w-1:0]     rm_data,
    output logic [data_w-1:0]     rd_data
);

    logic [data_w-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // second port, base register update
            if (w_en2) begin
                regs[rn] <= base_result;
            end
            // first port, rd wins if both hit one register
            if (w_en1) begin
                regs[rd] <= alu_result;
            end else if (w_en3) begin
                regs[rd] <= load_data;
            end
        end
    end

    assign rn_data = regs[rn];
    assign rm_data = regs[rm];
    // store data source
    assign rd_data = regs[rd];

endmodule

//--- src/execute_datapath.sv
`timescale 1ns/10ps

module execute_datapath
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en_A,
    input  logic               en_B,
    input  logic               sel_A,
    input  logic               sel_B,
    input  logic               sel_post_indexing,
    input  alu_op_e            alu_op,
    input  logic               en_C,
    input  logic               en_status,
    input  logic [data_w-1:0]  rn_data,
    input  logic [data_w-1:0]  rm_data,
    input  logic [data_w-1:0]  rd_data,
    input  logic [imm_w-1:0]   imm,
    input  logic [data_w-1:0]  pc,
    input  logic               sel_addr_data,
    input  logic [data_w-1:0]  wb_dat_i,
    input  logic               wb_ack,
    output logic [data_w-1:0]  alu_result,
    output logic [data_w-1:0]  base_result,
    output logic [data_w-1:0]  load_data,
    output logic [data_w-1:0]  bus_adr,
    output logic [data_w-1:0]  bus_dat,
    output logic [flag_w-1:0]  status_flags
);

    logic [data_w-1:0] a_reg;
    logic [data_w-1:0] b_reg;
    logic [data_w-1:0] c_reg;
    logic [data_w-1:0] imm_ext;
    logic [data_w-1:0] alu_out;
    logic [data_w:0]   wide;
    logic              carry;
    logic              ovf;
    logic [flag_w-1:0] flags_next;

    assign imm_ext = {{(data_w - imm_w){1'b0}}, imm};

    always_ff @(posedge clk) begin
        if (en_A) begin
            a_reg <= sel_A ? '0 : rn_data;
        end
        if (en_B) begin
            b_reg <= sel_B ? imm_ext : rm_data;
        end
        if (en_C) begin
            c_reg <= alu_out;
        end
        // only data reads land here
        if (wb_ack && sel_addr_data) begin
            load_data <= wb_dat_i;
        end
    end

    always_comb begin
        wide    = '0;
        carry   = 1'b0;
        ovf     = 1'b0;
        alu_out = a_reg;
        case (alu_op)
            ADD: begin
                wide    = {1'b0, a_reg} + {1'b0, b_reg};
                alu_out = wide[data_w-1:0];
                carry   = wide[data_w];
                ovf     = (a_reg[data_w-1] == b_reg[data_w-1]) &&
                          (alu_out[data_w-1] != a_reg[data_w-1]);
            end
            SUB: begin
                // carry set means no borrow
                wide    = {1'b0, a_reg} + {1'b0, ~b_reg} + {{data_w{1'b0}}, 1'b1};
                alu_out = wide[data_w-1:0];
                carry   = wide[data_w];
                ovf     = (a_reg[data_w-1] != b_reg[data_w-1]) &&
                          (alu_out[data_w-1] != a_reg[data_w-1]);
            end
            AND:     alu_out = a_reg & b_reg;
            ORR:     alu_out = a_reg | b_reg;
            XOR:     alu_out = a_reg ^ b_reg;
            default: alu_out = a_reg;
        endcase
    end

    always_comb begin
        flags_next         = '0;
        flags_next[flag_n] = alu_out[data_w-1];
        flags_next[flag_z] = (alu_out == '0);
        flags_next[flag_c] = carry;
        flags_next[flag_v] = ovf;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_flags <= '0;
        end else if (en_status) begin
            status_flags <= flags_next;
        end
    end

    // result bus follows the ALU while C loads, then shows the held result
    assign alu_result  = en_C ? alu_out : c_reg;
    assign base_result = alu_out;

    // post-indexed accesses use the untouched base
    assign bus_adr = sel_addr_data ? (sel_post_indexing ? a_reg : alu_out) : pc;
    assign bus_dat = rd_data;

endmodule

//--- src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output logic [data_w-1:0] wb_adr,
    output logic [data_w-1:0] wb_dat_o,
    input  logic [data_w-1:0] wb_dat_i,
    input  logic              wb_ack,
    output logic              halted,
    output logic [flag_w-1:0] status_flags
);

    logic                  load_pc;
    logic                  sel_pc;
    logic                  load_ir;
    logic                  w_en1;
    logic                  w_en2;
    logic                  w_en3;
    logic                  en_A;
    logic                  en_B;
    logic                  sel_A;
    logic                  sel_B;
    logic                  sel_post_indexing;
    alu_op_e               alu_op;
    logic                  en_C;
    logic                  en_status;
    logic                  sel_addr_data;
    op_e                   opcode;
    logic                  P;
    logic                  U;
    logic                  W;
    logic [data_w-1:0]     pc;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rn;
    logic [reg_addr_w-1:0] rm;
    logic [imm_w-1:0]      imm;
    logic [data_w-1:0]     rn_data;
    logic [data_w-1:0]     rm_data;
    logic [data_w-1:0]     rd_data;
    logic [data_w-1:0]     alu_result;
    logic [data_w-1:0]     base_result;
    logic [data_w-1:0]     load_data;

    // classic cycle, cyc and stb move together
    assign wb_stb = wb_cyc;

    cpu_controller u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .opcode            (opcode),
        .P                 (P),
        .U                 (U),
        .W                 (W),
        .wb_ack            (wb_ack),
        .load_pc           (load_pc),
        .sel_pc            (sel_pc),
        .load_ir           (load_ir),
        .w_en1             (w_en1),
        .w_en2             (w_en2),
        .w_en3             (w_en3),
        .en_A              (en_A),
        .en_B              (en_B),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .sel_post_indexing (sel_post_indexing),
        .alu_op            (alu_op),
        .en_C              (en_C),
        .en_status         (en_status),
        .bus_req           (wb_cyc),
        .bus_we            (wb_we),
        .sel_addr_data     (sel_addr_data),
        .halted            (halted)
    );

    instr_fetch u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_pc  (load_pc),
        .sel_pc   (sel_pc),
        .load_ir  (load_ir),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .pc       (pc),
        .opcode   (opcode),
        .rd       (rd),
        .rn       (rn),
        .rm       (rm),
        .P        (P),
        .U        (U),
        .W        (W),
        .imm      (imm)
    );

    register_file u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd          (rd),
        .rn          (rn),
        .rm          (rm),
        .w_en1       (w_en1),
        .w_en2       (w_en2),
        .w_en3       (w_en3),
        .alu_result  (alu_result),
        .base_result (base_result),
        .load_data   (load_data),
        .rn_data     (rn_data),
        .rm_data     (rm_data),
        .rd_data     (rd_data)
    );

    execute_datapath u_exec (
        .clk               (clk),
        .rst_n             (rst_n),
        .en_A              (en_A),
        .en_B              (en_B),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .sel_post_indexing (sel_post_indexing),
        .alu_op            (alu_op),
        .en_C              (en_C),
        .en_status         (en_status),
        .rn_data           (rn_data),
        .rm_data           (rm_data),
        .rd_data           (rd_data),
        .imm               (imm),
        .pc                (pc),
        .sel_addr_data     (sel_addr_data),
        .wb_dat_i          (wb_dat_i),
        .wb_ack            (wb_ack),
        .alu_result        (alu_result),
        .base_result       (base_result),
        .load_data         (load_data),
        .bus_adr           (wb_adr),
        .bus_dat           (wb_dat_o),
        .status_flags      (status_flags)
    );

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int clk_period = 100;
    localparam int mem_words  = 256;
    localparam int max_instr  = 40;
    localparam int max_wait   = 3;
    localparam int timeout_ns = max_instr * (10 + max_wait) * clk_period + 10 * clk_period;

    logic              clk;
    logic              rst_n;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [data_w-1:0] wb_adr;
    logic [data_w-1:0] wb_dat_o;
    logic [data_w-1:0] wb_dat_i;
    logic              wb_ack;
    logic              halted;
    logic [flag_w-1:0] status_flags;

    logic [data_w-1:0] mem [mem_words];
    logic [data_w-1:0] ref_mem [mem_words];
    logic [flag_w-1:0] exp_flags;
    logic [data_w-1:0] exp_adr_q [$];
    logic              exp_we_q [$];
    logic [data_w-1:0] exp_dat_q [$];
    logic [data_w-1:0] act_adr_q [$];
    logic              act_we_q [$];
    logic [data_w-1:0] act_dat_q [$];

    logic [31:0]       lfsr;
    int                errors;
    int                prog_len;
    bit                busy;
    logic [1:0]        wait_left;
    logic [data_w-1:0] req_adr;
    logic              req_we;
    logic [data_w-1:0] req_dat;

    cpu_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_o     (wb_dat_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .halted       (halted),
        .status_flags (status_flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired, the CPU never halted");
        $display("TB FAILED");
        $finish;
    end

    // taps 32,22,2,1
    function automatic logic next_bit();
        logic b;
        b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc(op_e op, int rd, int rn, int rm,
                                        bit p, bit u, bit w, logic [9:0] imm);
        logic [31:0] word;
        word = {op, rd[3:0], rn[3:0], rm[3:0], p, u, w, imm};
        return word;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_len] = word;
        prog_len++;
    endtask

    // memory slave that answers each request after a random wait
    always @(negedge clk) begin
        if (wb_stb !== wb_cyc) begin
            $display("stb and cyc differ at %0t", $time);
            errors++;
        end
        if (halted && wb_cyc) begin
            $display("bus request seen after halt at %0t", $time);
            errors++;
        end
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = {next_bit(), next_bit()};
                req_adr   = wb_adr;
                req_we    = wb_we;
                req_dat   = wb_dat_o;
            end else begin
                check_val("stb hold adr", req_adr, wb_adr);
                check_val("stb hold we", {31'b0, req_we}, {31'b0, wb_we});
                check_val("stb hold dat", req_dat, wb_dat_o);
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                act_adr_q.push_back(wb_adr);
                act_we_q.push_back(wb_we);
                act_dat_q.push_back(wb_we ? wb_dat_o : '0);
                if (wb_adr >= mem_words * 4 || wb_adr[1:0] != 2'b00) begin
                    $display("access to bad address %h", wb_adr);
                    errors++;
                end else if (wb_we) begin
                    mem[wb_adr[9:2]] = wb_dat_o;
                end else begin
                    wb_dat_i = mem[wb_adr[9:2]];
                end
                wb_ack = 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    // ISA model that fills ref_mem, exp_flags and the trace
    function automatic void run_model();
        logic [31:0] r [16];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] off;
        logic [31:0] addr;
        logic [6:0]  op;
        logic [3:0]  rd_i;
        logic [3:0]  rn_i;
        logic [3:0]  rm_i;
        for (int i = 0; i < 16; i++) begin
            r[i] = '0;
        end
        pc        = '0;
        exp_flags = '0;
        for (int step = 0; step < max_instr; step++) begin
            exp_adr_q.push_back(pc);
            exp_we_q.push_back(1'b0);
            exp_dat_q.push_back('0);
            ins  = ref_mem[pc[9:2]];
            op   = ins[31:25];
            rd_i = ins[24:21];
            rn_i = ins[20:17];
            rm_i = ins[16:13];
            if (op == HLT) begin
                break;
            end
            a = op[3] ? r[rn_i] : '0;
            b = op[4] ? r[rm_i] : {22'b0, ins[9:0]};
            if (op[6]) begin
                off  = ins[11] ? a + b : a - b;
                addr = ins[12] ? off : a;
                exp_adr_q.push_back(addr);
                exp_we_q.push_back(op[5]);
                exp_dat_q.push_back(op[5] ? r[rd_i] : '0);
                if (op[5]) begin
                    ref_mem[addr[9:2]] = r[rd_i];
                end
                if (!ins[12] || ins[10]) begin
                    r[rn_i] = off;
                end
                // load data wins over the base update
                if (!op[5]) begin
                    r[rd_i] = ref_mem[addr[9:2]];
                end
            end else begin
                case (op)
                    MOV_I, ADD_I, ADD_R: r[rd_i] = a + b;
                    SUB_I, SUB_R:        r[rd_i] = a - b;
                    AND_R:               r[rd_i] = a & b;
                    ORR_R:               r[rd_i] = a | b;
                    XOR_R:               r[rd_i] = a ^ b;
                    CMP_R: begin
                        res       = a - b;
                        exp_flags = {res[31], res == 0, a >= b,
                                     (a[31] != b[31]) && (res[31] != a[31])};
                    end
                    default: begin
                    end
                endcase
            end
            pc = pc + 4;
        end
    endfunction

    task automatic load_program();
        prog_len = 0;
        // data area pattern from the full word index
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
        end
        emit(enc(MOV_I, 1, 0, 0, 0, 0, 0, 10'h2a5));
        emit(enc(MOV_I, 2, 0, 0, 0, 0, 0, 10'h3f3));
        emit(enc(MOV_I, 10, 0, 0, 0, 0, 0, 10'h100));
        emit(enc(ADD_R, 3, 1, 2, 0, 0, 0, 0));
        emit(enc(SUB_R, 4, 1, 2, 0, 0, 0, 0));
        emit(enc(AND_R, 5, 1, 2, 0, 0, 0, 0));
        emit(enc(ORR_R, 6, 1, 2, 0, 0, 0, 0));
        emit(enc(XOR_R, 7, 1, 2, 0, 0, 0, 0));
        emit(enc(ADD_I, 8, 1, 0, 0, 0, 0, 10'h3ff));
        emit(enc(SUB_I, 9, 1, 0, 0, 0, 0, 10'h005));
        // post-indexed stores walk r10 through the result block
        for (int k = 1; k <= 9; k++) begin
            emit(enc(STR_I, k, 10, 0, 0, 1, 0, 4));
        end
        emit(enc(MOV_I, 11, 0, 0, 0, 0, 0, 10'h180));
        emit(enc(MOV_I, 14, 0, 0, 0, 0, 0, 10'h008));
        emit(enc(LDR_I, 12, 11, 0, 1, 1, 1, 8));
        emit(enc(LDR_R, 13, 11, 14, 0, 0, 0, 0));
        emit(enc(STR_R, 12, 11, 14, 1, 0, 0, 0));
        emit(enc(STR_I, 13, 11, 0, 1, 1, 0, 16));
        emit(enc(LDR_I, 1, 11, 0, 0, 1, 1, 4));
        emit(enc(STR_R, 11, 10, 14, 1, 1, 1, 0));
        emit(enc(STR_I, 10, 11, 0, 1, 1, 0, 0));
        emit(enc(STR_I, 1, 11, 0, 1, 1, 0, 12));
        // down-indexed write-back in both modes
        emit(enc(STR_I, 4, 11, 0, 1, 0, 1, 8));
        emit(enc(LDR_I, 15, 11, 0, 0, 0, 1, 4));
        emit(enc(STR_I, 15, 11, 0, 1, 1, 0, 16));
        emit(enc(CMP_R, 3, 2, 1, 0, 0, 0, 0));
        emit(enc(NOP, 0, 0, 0, 0, 0, 0, 0));
        emit(enc(STR_I, 3, 11, 0, 1, 1, 0, 32));
        emit(enc(HLT, 0, 0, 0, 0, 0, 0, 0));
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = mem[i];
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        wb_dat_i  = '0;
        wb_ack    = 1'b0;
        lfsr      = 32'h9f11_11fd;
        errors    = 0;
        busy      = 1'b0;
        wait_left = 0;
        load_program();
        run_model();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("reset cyc", 32'd0, {31'b0, wb_cyc});
        check_val("reset stb", 32'd0, {31'b0, wb_stb});
        check_val("reset halted", 32'd0, {31'b0, halted});

        wait (halted === 1'b1);
        // no more bus traffic expected
        repeat (20) @(negedge clk);

        check_val("halted", 32'd1, {31'b0, halted});
        check_val("status_flags", {28'b0, exp_flags}, {28'b0, status_flags});
        if (act_adr_q.size() > 0) begin
            check_val("first fetch adr", 32'd0, act_adr_q[0]);
        end
        if (act_adr_q.size() != exp_adr_q.size()) begin
            $display("bus trace holds %0d accesses, the model gives %0d",
                     act_adr_q.size(), exp_adr_q.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_adr_q.size(); i++) begin
                check_val($sformatf("trace adr %0d", i), exp_adr_q[i], act_adr_q[i]);
                check_val($sformatf("trace we %0d", i), {31'b0, exp_we_q[i]},
                          {31'b0, act_we_q[i]});
                check_val($sformatf("trace dat %0d", i), exp_dat_q[i], act_dat_q[i]);
            end
        end
        for (int i = 0; i < mem_words; i++) begin
            check_val($sformatf("mem word %0d", i), ref_mem[i], mem[i]);
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
src/cpu_pkg.sv
src/cpu_controller.sv
src/instr_fetch.sv
src/register_file.sv
src/execute_datapath.sv
src/cpu_top.sv
sim/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
